/* Makefile */
TOP := tb_fetch_frontend

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f tb.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f tb.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'NO ERRORS'

clean:
	rm -rf obj_dir

/* sim/tb_fetch_frontend.sv */
`default_nettype none

module tb_fetch_frontend;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int clk_period         = 8;
  localparam int seq_transfers      = 40;
  localparam int stall_transfers    = 60;
  localparam int redirect_transfers = 20;
  localparam int planned_transfers  = seq_transfers + stall_transfers + 2 * redirect_transfers;

  // words in this range answer with a bus error
  localparam logic [31:0] err_lo = 32'h0000_0220;
  localparam logic [31:0] err_hi = 32'h0000_0240;

  logic        clk_i          = 1'b0;
  logic        rst_ni         = 1'b0;
  logic        redirect_i     = 1'b0;
  logic [31:0] redirect_pc_i  = '0;
  logic        mem_ack_i      = 1'b0;
  logic [31:0] mem_rdata_i    = '0;
  logic        mem_err_i      = 1'b0;
  logic        decode_ready_i = 1'b0;

  logic        mem_req_o;
  logic [31:0] mem_adr_o;
  logic        instr_valid_o;
  logic [31:0] instr_o;
  logic [31:0] instr_pc_o;
  logic        instr_compressed_o;
  logic        instr_error_o;
  logic        instr_misaligned_o;

  int seed      = 39;
  int errors    = 0;
  int transfers = 0;

  // memory model and ready pattern
  bit busy         = 1'b0;
  int delay_left   = 0;
  int stall_left   = 0;
  int rnd          = 0;
  bit ready_random = 1'b0;

  // reference walk
  logic [31:0] walk_pc    = fetch_pkg::boot_pc;
  logic        mis_active = 1'b0;
  logic [29:0] mis_word   = '0;

  // what the stimulus reached
  int err_hits      = 0;
  int mis_hits      = 0;
  int straddle_hits = 0;
  int held_cycles   = 0;

  // previous cycle values for the hold checks
  bit          held        = 1'b0;
  logic [31:0] held_instr  = '0;
  logic [31:0] held_pc     = '0;
  bit          req_waiting = 1'b0;
  logic [31:0] held_adr    = '0;
  int          since_reset = 0;

  always #(clk_period / 2) clk_i = ~clk_i;

  fetch_frontend i_dut (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .redirect_i         (redirect_i),
    .redirect_pc_i      (redirect_pc_i),
    .mem_req_o          (mem_req_o),
    .mem_adr_o          (mem_adr_o),
    .mem_ack_i          (mem_ack_i),
    .mem_rdata_i        (mem_rdata_i),
    .mem_err_i          (mem_err_i),
    .instr_valid_o      (instr_valid_o),
    .instr_o            (instr_o),
    .instr_pc_o         (instr_pc_o),
    .instr_compressed_o (instr_compressed_o),
    .instr_error_o      (instr_error_o),
    .instr_misaligned_o (instr_misaligned_o),
    .decode_ready_i     (decode_ready_i)
  );

  //////////////////////////////////////////////////////////////////////
  // memory contents and reporting

  // hashed halfword index gives about one full encoding in four
  function automatic logic [15:0] halfword_at(input logic [31:0] adr);
    logic [31:0] mix;

    mix = {1'b0, adr[31:1]} * 32'h9e37_79b1;
    return mix[31:16];
  endfunction

  function automatic logic [31:0] word_at(input logic [31:0] adr);
    return {halfword_at({adr[31:2], 2'b10}), halfword_at({adr[31:2], 2'b00})};
  endfunction

  function automatic logic in_err_window(input logic [31:0] adr);
    return (adr >= err_lo) && (adr < err_hi);
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
    errors++;
    $display("Error at %0d ns: %s expected %h, actual %h", $time, name, exp, act);
  endtask

  task automatic report_failure(input string msg);
    errors++;
    $display("Error at %0d ns: %s", $time, msg);
  endtask

  task automatic print_summary();
    $display("transfers checked %0d, errors %0d", transfers, errors);
  endtask

  //////////////////////////////////////////////////////////////////////
  // stimulus

  // bus answers after 1 to 4 cycles with a one cycle ack
  always @(posedge clk_i)
  begin
    if (!rst_ni)
      busy = 1'b0;
    else if (mem_ack_i)
    begin
      mem_ack_i <= 1'b0;
      mem_err_i <= 1'b0;
    end
    else if (mem_req_o)
    begin
      if (!busy)
      begin
        busy       = 1'b1;
        delay_left = $random(seed) & 3;
      end
      if (delay_left == 0)
      begin
        mem_ack_i   <= 1'b1;
        mem_rdata_i <= word_at(mem_adr_o);
        mem_err_i   <= in_err_window(mem_adr_o);
        busy        = 1'b0;
      end
      else
        delay_left--;
    end

    // random ready with some long stalls that fill the queue
    if (!ready_random)
      decode_ready_i <= 1'b1;
    else if (stall_left > 0)
    begin
      decode_ready_i <= 1'b0;
      stall_left--;
    end
    else
    begin
      rnd = $random(seed);
      if (rnd[3:0] == 4'd0)
        stall_left = 24;
      decode_ready_i <= (rnd[5:4] != 2'b00);
    end
  end

  // waits until a request is on the bus so its answer goes stale
  task automatic redirect_to(input logic [31:0] target);
    @(negedge clk_i);
    while (!(mem_req_o && !mem_ack_i))
      @(negedge clk_i);
    @(posedge clk_i);
    redirect_i    <= 1'b1;
    redirect_pc_i <= target;
    @(posedge clk_i);
    redirect_i    <= 1'b0;
  endtask

  task automatic wait_transfers(input int count);
    int target;

    target = transfers + count;
    while (transfers < target)
      @(posedge clk_i);
  endtask

  //////////////////////////////////////////////////////////////////////
  // reference walk and checks

  task automatic check_transfer();
    logic [15:0] first;
    logic        full;
    logic [31:0] exp_instr;
    logic        exp_err;
    logic        exp_mis;

    first     = halfword_at(walk_pc);
    full      = (first[1:0] == 2'b11);
    exp_instr = full ? {halfword_at(walk_pc + 32'd2), first} : {16'h0000, first};
    // status comes from the word holding the first parcel
    exp_err   = in_err_window(walk_pc);
    exp_mis   = mis_active && (walk_pc[31:2] == mis_word);

    assert (instr_o == exp_instr)
      else report_mismatch("instr_o", exp_instr, instr_o);
    assert (instr_pc_o == walk_pc)
      else report_mismatch("instr_pc_o", walk_pc, instr_pc_o);
    assert (instr_compressed_o == !full)
      else report_mismatch("instr_compressed_o", 32'(!full), 32'(instr_compressed_o));
    assert (instr_error_o == exp_err)
      else report_mismatch("instr_error_o", 32'(exp_err), 32'(instr_error_o));
    assert (instr_misaligned_o == exp_mis)
      else report_mismatch("instr_misaligned_o", 32'(exp_mis), 32'(instr_misaligned_o));

    if (exp_err)
      err_hits++;
    if (exp_mis)
      mis_hits++;
    if (full && walk_pc[1])
      straddle_hits++;
    walk_pc = walk_pc + (full ? 32'd4 : 32'd2);
    transfers++;
  endtask

  // checks on the falling edge
  always @(negedge clk_i)
  begin
    if (!rst_ni || since_reset == 0)
    begin
      assert (!mem_req_o)
        else report_mismatch("mem_req_o", 32'd0, 32'(mem_req_o));
      assert (!instr_valid_o)
        else report_mismatch("instr_valid_o", 32'd0, 32'(instr_valid_o));
    end
    if (rst_ni)
    begin
      // stalled instruction must stay put
      if (held)
      begin
        assert (instr_valid_o)
          else report_mismatch("instr_valid_o", 32'd1, 32'(instr_valid_o));
        assert (instr_o == held_instr)
          else report_mismatch("instr_o", held_instr, instr_o);
        assert (instr_pc_o == held_pc)
          else report_mismatch("instr_pc_o", held_pc, instr_pc_o);
      end
      if (req_waiting)
      begin
        assert (mem_adr_o == held_adr)
          else report_mismatch("mem_adr_o", held_adr, mem_adr_o);
      end

      if (instr_valid_o && decode_ready_i)
        check_transfer();
      // new walk starts at the redirect target
      if (redirect_i)
      begin
        walk_pc    = {redirect_pc_i[31:1], 1'b0};
        mis_active = redirect_pc_i[0];
        mis_word   = redirect_pc_i[31:2];
      end

      held        = instr_valid_o && !decode_ready_i && !redirect_i;
      held_instr  = instr_o;
      held_pc     = instr_pc_o;
      req_waiting = mem_req_o && !mem_ack_i;
      held_adr    = mem_adr_o;
      if (held)
        held_cycles++;
      since_reset++;
    end
  end

  // request drops after each ack so only one word is in flight
  assert property (@(posedge clk_i) disable iff (!rst_ni) mem_ack_i |=> !mem_req_o)
    else report_mismatch("mem_req_o", 32'd0, 32'd1);

  // request held until the ack
  assert property (@(posedge clk_i) disable iff (!rst_ni)
                   mem_req_o && !mem_ack_i |=> mem_req_o)
    else report_mismatch("mem_req_o", 32'd1, 32'd0);

  //////////////////////////////////////////////////////////////////////
  // test sequence

  initial
  begin
    repeat (16) @(posedge clk_i);
    rst_ni <= 1'b1;

    wait_transfers(seq_transfers);

    ready_random <= 1'b1;
    wait_transfers(stall_transfers);
    ready_random <= 1'b0;

    // even halfword target and then an odd one
    redirect_to(32'h0000_0402);
    wait_transfers(redirect_transfers);
    redirect_to(32'h0000_0507);
    wait_transfers(redirect_transfers);

    if (err_hits == 0)
      report_failure("no instruction came from the error window");
    if (mis_hits == 0)
      report_failure("no misaligned instruction after the odd redirect");
    if (straddle_hits == 0)
      report_failure("no 32-bit instruction crossed a word boundary");
    if (held_cycles == 0)
      report_failure("decode never stalled a valid instruction");

    print_summary();
    if (errors == 0)
      $display("NO ERRORS");
    else
      $display("ERRORS FOUND");
    $finish;
  end

  // about 40 cycles per planned transfer
  initial
  begin
    #(planned_transfers * 40 * clk_period);
    report_failure("timeout, the instruction stream stopped");
    print_summary();
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

`default_nettype wire

/* source/fetch_frontend.sv */
`default_nettype none

module fetch_frontend (
  input  wire logic        clk_i,
  input  wire logic        rst_ni,

  // new program counter, flushes everything in flight
  input  wire logic        redirect_i,
  input  wire logic [31:0] redirect_pc_i,

  // memory port
  output logic             mem_req_o,
  output logic [31:0]      mem_adr_o,
  input  wire logic        mem_ack_i,
  input  wire logic [31:0] mem_rdata_i,
  input  wire logic        mem_err_i,

  // decode port
  output logic             instr_valid_o,
  output logic [31:0]      instr_o,
  output logic [31:0]      instr_pc_o,
  output logic             instr_compressed_o,
  output logic             instr_error_o,
  output logic             instr_misaligned_o,
  input  wire logic        decode_ready_i
);

  parcel_push_if push_bus ();
  parcel_pull_if pull_bus ();

  fetch_requester u_requester (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .redirect_i    (redirect_i),
    .redirect_pc_i (redirect_pc_i),
    .mem_req_o     (mem_req_o),
    .mem_adr_o     (mem_adr_o),
    .mem_ack_i     (mem_ack_i),
    .mem_rdata_i   (mem_rdata_i),
    .mem_err_i     (mem_err_i),
    .push          (push_bus.requester)
  );

  // a redirect empties the queue
  parcel_queue u_queue (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .flush_i (redirect_i),
    .push    (push_bus.queue),
    .pull    (pull_bus.queue)
  );

  instr_extractor u_extractor (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .redirect_i         (redirect_i),
    .redirect_pc_i      (redirect_pc_i),
    .decode_ready_i     (decode_ready_i),
    .instr_valid_o      (instr_valid_o),
    .instr_o            (instr_o),
    .instr_pc_o         (instr_pc_o),
    .instr_compressed_o (instr_compressed_o),
    .instr_error_o      (instr_error_o),
    .instr_misaligned_o (instr_misaligned_o),
    .pull               (pull_bus.extractor)
  );

endmodule

`default_nettype wire

/* source/fetch_pkg.sv */
`default_nettype none

package fetch_pkg;

  //////////////////////////////////////////////////////////////////////
  // sizes

  // one parcel is half of a 32-bit word
  localparam int parcel_size = 16;

  // most parcels per push and per pull
  localparam int wr_parcels = 2;
  localparam int rd_parcels = 2;

  // parcels held in the queue
  localparam int queue_depth = 8;

  // fill level counts 0 up to queue_depth inclusive
  localparam int level_bits = $clog2(queue_depth + 1);

  // pull count 0 to rd_parcels
  localparam int pull_bits = $clog2(rd_parcels + 1);

  typedef logic [parcel_size-1:0] parcel_t;
  typedef logic [level_bits-1:0]  level_t;

  // leaves room for one response in flight plus one being pushed
  localparam level_t almost_full_level = level_t'(queue_depth - wr_parcels - 2);

  // low half of addi x0,x0,0
  localparam parcel_t nop_parcel = 16'h0013;

  // program counter out of reset, word aligned
  localparam logic [31:0] boot_pc = 32'h0000_0200;

  //////////////////////////////////////////////////////////////////////
  // types

  // per parcel status, only parcel 0 is looked at by the extractor
  typedef struct packed {
    logic misaligned;
    logic error;
  } parcel_status_t;

  // bus request FSM
  typedef enum logic [1:0] {idle, wait_ack, drop_ack} fetch_state_e;

  // low two bits of the first parcel, 2'b11 means 32-bit
  typedef enum logic {kind_compressed, kind_full} parcel_kind_e;

endpackage

`default_nettype wire

/* source/fetch_requester.sv */
`default_nettype none

module fetch_requester (
  input  wire logic        clk_i,
  input  wire logic        rst_ni,
  input  wire logic        redirect_i,
  input  wire logic [31:0] redirect_pc_i,
  output logic             mem_req_o,
  output logic [31:0]      mem_adr_o,
  input  wire logic        mem_ack_i,
  input  wire logic [31:0] mem_rdata_i,
  input  wire logic        mem_err_i,
  parcel_push_if.requester push
);

  fetch_pkg::fetch_state_e state;

  // next word to request and the flags for its first response
  logic [31:0] fetch_adr;
  logic        pend_offset;
  logic        pend_misaligned;

  // flags of the request on the bus
  logic        req_offset;
  logic        req_misaligned;

  // what goes out if a request starts this cycle
  logic        issue;
  logic [31:0] issue_adr;
  logic        issue_offset;
  logic        issue_misaligned;

  // registered response
  logic                                           rsp_valid;
  fetch_pkg::parcel_t [fetch_pkg::wr_parcels-1:0] rsp_data;
  fetch_pkg::parcel_status_t                      rsp_status;
  logic                                           rsp_offset;

  //////////////////////////////////////////////////////////////////////
  // request side

  // only from idle, and only with room for the answer
  assign issue = (state == fetch_pkg::idle) && !push.almost_full;

  // a redirect in the same cycle wins over the running address
  assign issue_adr        = redirect_i ? {redirect_pc_i[31:2], 2'b00} : fetch_adr;
  assign issue_offset     = redirect_i ? redirect_pc_i[1] : pend_offset;
  assign issue_misaligned = redirect_i ? redirect_pc_i[0] : pend_misaligned;

  always_ff @(posedge clk_i, negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      fetch_adr       <= {fetch_pkg::boot_pc[31:2], 2'b00};
      pend_offset     <= fetch_pkg::boot_pc[1];
      pend_misaligned <= fetch_pkg::boot_pc[0];
    end
    else if (redirect_i || issue)
    begin
      // flags only belong to the first word after a redirect
      fetch_adr       <= issue ? issue_adr + 32'd4 : issue_adr;
      pend_offset     <= issue ? 1'b0 : issue_offset;
      pend_misaligned <= issue ? 1'b0 : issue_misaligned;
    end
  end

  // held stable while the request is out
  always_ff @(posedge clk_i)
  begin
    if (issue)
    begin
      mem_adr_o      <= issue_adr;
      req_offset     <= issue_offset;
      req_misaligned <= issue_misaligned;
    end
  end

  // drop_ack keeps the request up and throws the answer away
  always_ff @(posedge clk_i, negedge rst_ni)
  begin
    if (!rst_ni)
      state <= fetch_pkg::idle;
    else
    begin
      case (state)
        fetch_pkg::idle:
          if (issue)
            state <= fetch_pkg::wait_ack;
        fetch_pkg::wait_ack:
          if (mem_ack_i)
            state <= fetch_pkg::idle;
          else if (redirect_i)
            state <= fetch_pkg::drop_ack;
        default:
          if (mem_ack_i)
            state <= fetch_pkg::idle;
      endcase
    end
  end

  assign mem_req_o = (state != fetch_pkg::idle);

  //////////////////////////////////////////////////////////////////////
  // response side

  // an ack together with a redirect is stale too
  always_ff @(posedge clk_i, negedge rst_ni)
  begin
    if (!rst_ni)
      rsp_valid <= 1'b0;
    else
      rsp_valid <= mem_ack_i && (state == fetch_pkg::wait_ack) && !redirect_i;
  end

  always_ff @(posedge clk_i)
  begin
    if (mem_ack_i)
    begin
      rsp_data              <= mem_rdata_i;
      rsp_status.error      <= mem_err_i;
      rsp_status.misaligned <= req_misaligned;
      rsp_offset            <= req_offset;
    end
  end

  // offset start skips the low parcel
  assign push.parcel       = rsp_data;
  assign push.parcel_valid = !rsp_valid ? 2'b00 : (rsp_offset ? 2'b10 : 2'b11);
  assign push.status       = rsp_status;

endmodule

`default_nettype wire

/* source/instr_extractor.sv */
`default_nettype none

module instr_extractor (
  input  wire logic        clk_i,
  input  wire logic        rst_ni,
  input  wire logic        redirect_i,
  input  wire logic [31:0] redirect_pc_i,
  input  wire logic        decode_ready_i,
  output logic             instr_valid_o,
  output logic [31:0]      instr_o,
  output logic [31:0]      instr_pc_o,
  output logic             instr_compressed_o,
  output logic             instr_error_o,
  output logic             instr_misaligned_o,
  parcel_pull_if.extractor pull
);

  fetch_pkg::parcel_kind_e kind;
  logic                    transfer;
  logic [31:0]             pc;

  // length from the first parcel only
  assign kind = (pull.head[0][1:0] == 2'b11) ? fetch_pkg::kind_full
                                             : fetch_pkg::kind_compressed;

  // a 32-bit one needs both parcels in the queue
  assign instr_valid_o = (kind == fetch_pkg::kind_full) ? (pull.level >= 2)
                                                       : (pull.level >= 1);

  // upper half zero for 16-bit
  assign instr_o = (kind == fetch_pkg::kind_full)
                 ? {pull.head[1], pull.head[0]}
                 : {{fetch_pkg::parcel_size{1'b0}}, pull.head[0]};

  assign instr_compressed_o = (kind == fetch_pkg::kind_compressed);
  assign instr_error_o      = pull.head_status.error;
  assign instr_misaligned_o = pull.head_status.misaligned;
  assign instr_pc_o         = pc;

  assign transfer = instr_valid_o && decode_ready_i;

  // parcels used by this instruction
  always_comb
  begin
    if (!transfer)
      pull.pull = 2'd0;
    else if (kind == fetch_pkg::kind_full)
      pull.pull = 2'd2;
    else
      pull.pull = 2'd1;
  end

  //////////////////////////////////////////////////////////////////////
  // program counter

  // redirect wins over a transfer in the same cycle
  always_ff @(posedge clk_i, negedge rst_ni)
  begin
    if (!rst_ni)
      pc <= fetch_pkg::boot_pc;
    else if (redirect_i)
      pc <= {redirect_pc_i[31:1], 1'b0};
    else if (transfer)
      pc <= pc + ((kind == fetch_pkg::kind_full) ? 32'd4 : 32'd2);
  end

endmodule

`default_nettype wire

/* source/parcel_pull_if.sv */
`default_nettype none

interface parcel_pull_if;

  // two oldest parcels, head[0] is where the next instruction starts
  fetch_pkg::parcel_t [fetch_pkg::rd_parcels-1:0] head;

  // status of head[0]
  fetch_pkg::parcel_status_t head_status;

  // stored parcels
  fetch_pkg::level_t level;

  // parcels removed at the next edge, combinational from the extractor
  logic [fetch_pkg::pull_bits-1:0] pull;

  modport queue (
    output head,
    output head_status,
    output level,
    input  pull
  );

  modport extractor (
    input  head,
    input  head_status,
    input  level,
    output pull
  );

endinterface

`default_nettype wire

/* source/parcel_push_if.sv */
`default_nettype none

interface parcel_push_if;

  // word from the bus split in two parcels, parcel 0 is the low half
  fetch_pkg::parcel_t [fetch_pkg::wr_parcels-1:0] parcel;

  // one bit per parcel, low index first
  logic [fetch_pkg::wr_parcels-1:0] parcel_valid;

  // shared status of all parcels in this push
  fetch_pkg::parcel_status_t status;

  // registered in the queue, stops new requests
  logic almost_full;

  modport requester (
    output parcel,
    output parcel_valid,
    output status,
    input  almost_full
  );

  modport queue (
    input  parcel,
    input  parcel_valid,
    input  status,
    output almost_full
  );

endinterface

`default_nettype wire

/* source/parcel_queue.sv */
`default_nettype none

module parcel_queue (
  input  wire logic    clk_i,
  input  wire logic    rst_ni,
  input  wire logic    flush_i,
  parcel_push_if.queue push,
  parcel_pull_if.queue pull
);

  localparam int ext_depth = fetch_pkg::queue_depth + fetch_pkg::wr_parcels;

  // parcels and their status, entry 0 is the oldest
  fetch_pkg::parcel_t        [fetch_pkg::queue_depth-1:0] parcel_sr;
  fetch_pkg::parcel_status_t [fetch_pkg::queue_depth-1:0] status_sr;

  // next values, wider so a write at the top stays in range
  fetch_pkg::parcel_t        [ext_depth-1:0] nxt_parcel_sr;
  fetch_pkg::parcel_status_t [ext_depth-1:0] nxt_status_sr;

  fetch_pkg::parcel_t [fetch_pkg::wr_parcels-1:0] align_parcel;

  // write pointer, also the fill level
  fetch_pkg::level_t wadr;
  fetch_pkg::level_t nxt_wadr;

  //////////////////////////////////////////////////////////////////////
  // helpers

  // invalid parcels in front of the first valid one
  function automatic int align_cnt(input logic [fetch_pkg::wr_parcels-1:0] valid);
    bit found;

    found     = 1'b0;
    align_cnt = 0;
    for (int n = 0; n < fetch_pkg::wr_parcels; n++)
    begin
      if (!found)
      begin
        if (valid[n])
          found = 1'b1;
        else
          align_cnt++;
      end
    end
  endfunction

  function automatic fetch_pkg::level_t count_ones(
    input logic [fetch_pkg::wr_parcels-1:0] valid
  );
    count_ones = '0;
    for (int n = 0; n < fetch_pkg::wr_parcels; n++)
    begin
      if (valid[n])
        count_ones++;
    end
  endfunction

  //////////////////////////////////////////////////////////////////////
  // write pointer

  // first valid parcel lands at wadr
  assign align_parcel = push.parcel >> (align_cnt(push.parcel_valid) * fetch_pkg::parcel_size);

  assign nxt_wadr = wadr + count_ones(push.parcel_valid) - fetch_pkg::level_t'(pull.pull);

  always_ff @(posedge clk_i, negedge rst_ni)
  begin
    if (!rst_ni)
      wadr <= '0;
    else if (flush_i)
      wadr <= '0;
    else
      wadr <= nxt_wadr;
  end

  //////////////////////////////////////////////////////////////////////
  // shift registers

  // write at the pointer, then shift the pulled parcels out
  always_comb
  begin
    nxt_parcel_sr = {{fetch_pkg::wr_parcels{fetch_pkg::nop_parcel}}, parcel_sr};
    nxt_status_sr = {{fetch_pkg::wr_parcels{2'b00}}, status_sr};

    // status goes to every written slot, start of instruction unknown here
    if (|push.parcel_valid)
    begin
      for (int n = 0; n < fetch_pkg::wr_parcels; n++)
      begin
        nxt_parcel_sr[wadr + n] = align_parcel[n];
        nxt_status_sr[wadr + n] = push.status;
      end
    end

    nxt_parcel_sr = nxt_parcel_sr >> (pull.pull * fetch_pkg::parcel_size);
    nxt_status_sr = nxt_status_sr >> (pull.pull * $bits(fetch_pkg::parcel_status_t));
  end

  always_ff @(posedge clk_i)
  begin
    if (flush_i)
    begin
      parcel_sr <= {fetch_pkg::queue_depth{fetch_pkg::nop_parcel}};
      status_sr <= '0;
    end
    else
    begin
      parcel_sr <= nxt_parcel_sr[fetch_pkg::queue_depth-1:0];
      status_sr <= nxt_status_sr[fetch_pkg::queue_depth-1:0];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // outputs

  assign pull.head        = parcel_sr[fetch_pkg::rd_parcels-1:0];
  assign pull.head_status = status_sr[0];
  assign pull.level       = wadr;

  // from the next pointer so the requester sees it one edge earlier
  always_ff @(posedge clk_i, negedge rst_ni)
  begin
    if (!rst_ni)
      push.almost_full <= 1'b0;
    else if (flush_i)
      push.almost_full <= 1'b0;
    else
      push.almost_full <= (nxt_wadr >= fetch_pkg::almost_full_level);
  end

endmodule

`default_nettype wire

/* tb.f */
source/fetch_pkg.sv
source/parcel_push_if.sv
source/parcel_pull_if.sv
source/fetch_requester.sv
source/parcel_queue.sv
source/instr_extractor.sv
source/fetch_frontend.sv
sim/tb_fetch_frontend.sv
